/* rtl/sdram_cmd_pkg.sv */
// SDRAM pin-side types: data, bank and mask words
// command encodings on cs/ras/cas/we
// address word views (row, column, mode) and the burst length rule
package sdram_cmd_pkg;

    typedef logic [1:0]  bank_t;
    typedef logic [15:0] data_t;
    typedef logic [1:0]  mask_t;                // high = lane written or driven

    typedef struct packed {
        logic cs_n;
        logic ras_n;
        logic cas_n;
        logic we_n;
    } sdram_cmd_t;

    localparam sdram_cmd_t cmd_nop       = 4'b0111;
    localparam sdram_cmd_t cmd_activate  = 4'b0011;
    localparam sdram_cmd_t cmd_read      = 4'b0101;
    localparam sdram_cmd_t cmd_write     = 4'b0100;
    localparam sdram_cmd_t cmd_load_mode = 4'b0000;

    typedef union packed {
        logic [12:0] row;                       // activate
        struct packed {
            logic       rsvd;                   // A12
            logic       col_hi;                 // A11
            logic       a10;                    // auto precharge, unused
            logic [9:0] col_lo;
        } col;                                  // read / write
        struct packed {
            logic [5:0] rsvd;
            logic [2:0] cas_lat;
            logic       burst_type;
            logic [2:0] burst_code;
        } mode;                                 // load mode
    } sdram_addr_u;

    function automatic logic [3:0] burst_len(input logic [2:0] code);
        case (code)
            3'd0:    return 4'd1;
            3'd1:    return 4'd2;
            3'd2:    return 4'd4;
            3'd3:    return 4'd8;
            default: return 4'd1;               // full page not modelled
        endcase
    endfunction

endpackage

/* rtl/sdram_user_pkg.sv */
// user-side request and read response words
package sdram_user_pkg;

    // one burst request
    typedef struct packed {
        logic                 op;               // 1 = write
        sdram_cmd_pkg::bank_t bank;
        logic [12:0]          row;
        logic [10:0]          col;              // start column
        sdram_cmd_pkg::mask_t mask;             // applies to every beat
    } user_req_t;

    // one read beat
    typedef struct packed {
        sdram_cmd_pkg::data_t data;
        logic                 last;             // final beat of the burst
    } user_rsp_t;

endpackage

/* rtl/sdram_model.sv */
// behavioral x16 SDR SDRAM, one open bank/row
// mode register, burst FSM, tristate data bus, scaled memory array
`timescale 1ns/1ns

module sdram_model #(
    parameter int row_width = 6,
    parameter int col_width = 5
) (
    input  logic                      clk,
    input  logic                      cke,
    input  sdram_cmd_pkg::sdram_cmd_t cmd,
    input  logic [12:0]               a,
    input  sdram_cmd_pkg::bank_t      ba,
    input  sdram_cmd_pkg::mask_t      dqm,
    inout  sdram_cmd_pkg::data_t      dq
);
    import sdram_cmd_pkg::*;

    localparam int addr_width = 2 + row_width + col_width;

    typedef enum logic [1:0] {
        st_idle,
        st_wr_burst,
        st_cas_wait,
        st_data_out
    } state_t;

    state_t                st;
    sdram_addr_u           a_u;
    logic [2:0]            mode_cas;
    logic [3:0]            mode_bl;
    bank_t                 bank_lat;
    logic [12:0]           row_lat;
    logic [10:0]           col_full;
    logic [col_width-1:0]  col_start;
    logic [col_width-1:0]  col_ptr;
    logic [col_width-1:0]  wr_col;
    logic [3:0]            cnt;
    mask_t                 rd_mask;
    mask_t                 drv_en;
    logic                  is_act;
    logic                  is_rd;
    logic                  is_wr;
    logic                  is_lmr;
    logic                  wr_en;
    logic [addr_width-1:0] wr_idx;
    logic [addr_width-1:0] rd_idx;
    data_t                 rd_word;
    data_t                 lane_mask;

    data_t mem [2**addr_width];

    assign a_u    = a;
    assign is_act = (cmd == cmd_activate);
    assign is_rd  = (cmd == cmd_read);
    assign is_wr  = (cmd == cmd_write);
    assign is_lmr = (cmd == cmd_load_mode);

    assign col_full  = {a_u.col.col_hi, a_u.col.col_lo};
    assign col_start = col_full[col_width-1:0];    // wraps inside the scaled page

    // beat 0 lands with the write command itself
    assign wr_en  = is_wr || (st == st_wr_burst);
    assign wr_col = is_wr ? col_start : col_ptr;
    assign wr_idx = {bank_lat, row_lat[row_width-1:0], wr_col};
    assign rd_idx = {bank_lat, row_lat[row_width-1:0], col_ptr};

    assign rd_word   = mem[rd_idx];
    assign drv_en    = (st == st_data_out) ? rd_mask : 2'b00;
    assign lane_mask = {{8{drv_en[1]}}, {8{drv_en[0]}}};

    assign dq[7:0]  = drv_en[0] ? rd_word[7:0]  : 8'bz;
    assign dq[15:8] = drv_en[1] ? rd_word[15:8] : 8'bz;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            mode_cas <= 3'd2;
            mode_bl  <= 4'd1;
            bank_lat <= '0;
            row_lat  <= '0;
        end else begin
            if (is_lmr) begin
                mode_cas <= a_u.mode.cas_lat;
                mode_bl  <= burst_len(a_u.mode.burst_code);
            end
            if (is_act) begin
                bank_lat <= ba;
                row_lat  <= a_u.row;
            end
        end
    end

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            st      <= st_idle;
            cnt     <= '0;
            col_ptr <= '0;
            rd_mask <= '0;
        end else begin
            case (st)
                st_idle: begin
                    if (is_wr) begin
                        col_ptr <= col_start + 1'b1;
                        cnt     <= 4'd1;
                        if (mode_bl > 4'd1) begin
                            st <= st_wr_burst;
                        end
                    end else if (is_rd) begin
                        col_ptr <= col_start;
                        rd_mask <= dqm;                 // lanes driven for the whole burst
                        cnt     <= 4'd1;
                        st      <= st_cas_wait;
                    end
                end
                st_cas_wait: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == {1'b0, mode_cas} - 4'd1) begin
                        cnt <= '0;
                        st  <= st_data_out;
                    end
                end
                st_wr_burst, st_data_out: begin
                    col_ptr <= col_ptr + 1'b1;
                    cnt     <= cnt + 1'b1;
                    if (cnt == mode_bl - 4'd1) begin
                        st <= st_idle;
                    end
                end
                default: st <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en && dqm[0]) begin
            mem[wr_idx][7:0] <= dq[7:0];
        end
        if (wr_en && dqm[1]) begin
            mem[wr_idx][15:8] <= dq[15:8];
        end
    end

    a_cmd_idle: assert property (@(posedge clk) disable iff (!cke)
        (is_rd || is_wr) |-> (st == st_idle))
        else $error("read/write command during an active burst");

    a_cmd_bank: assert property (@(posedge clk) disable iff (!cke)
        (is_rd || is_wr) |-> (ba == bank_lat))
        else $error("read/write command to a bank that is not open");

    // a lane we drive must carry our own word, else someone else drives too
    a_dq_owner: assert property (@(posedge clk) disable iff (!cke)
        (drv_en != 2'b00) |-> (((dq ^ rd_word) & lane_mask) == 16'h0))
        else $error("dq driven by model and controller at once");

endmodule

/* rtl/sdram_ctrl.sv */
// SDRAM controller: mode setup after reset, open-row tracking,
// command sequencing and single-burst read/write transfer
`timescale 1ns/1ns

module sdram_ctrl #(
    parameter int row_width  = 6,
    parameter int col_width  = 5,
    parameter int cas_lat    = 2,
    parameter int burst_code = 2
) (
    input  logic                       clk,
    input  logic                       cke,
    input  logic                       req_valid,
    input  sdram_user_pkg::user_req_t  req,
    input  sdram_cmd_pkg::data_t       wr_data,
    output logic                       busy,
    output logic                       wr_take,
    output logic                       rsp_valid,
    output sdram_user_pkg::user_rsp_t  rsp,
    output sdram_cmd_pkg::sdram_cmd_t  cmd,
    output logic [12:0]                a,
    output sdram_cmd_pkg::bank_t       ba,
    output sdram_cmd_pkg::mask_t       dqm,
    inout  sdram_cmd_pkg::data_t       dq
);
    import sdram_cmd_pkg::*;
    import sdram_user_pkg::*;

    localparam logic [3:0] beat_total = burst_len(3'(burst_code));

    typedef enum logic [2:0] {
        st_mode_set,
        st_idle,
        st_activate,
        st_write,
        st_read_wait,
        st_read_cap
    } state_t;

    state_t      st;
    user_req_t   req_r;
    user_req_t   src;
    logic        accept;
    logic        hit;
    logic        go_rw;
    logic        open_valid;
    bank_t       open_bank;
    logic [12:0] open_row;
    logic [2:0]  wait_cnt;
    logic [3:0]  beats_left;
    logic [10:0] col_full;
    sdram_addr_u mode_word;
    sdram_addr_u row_word;
    sdram_addr_u col_word;

    assign accept = req_valid && !busy;            // strobes while busy are dropped
    assign src    = (st == st_idle) ? req : req_r;
    assign hit    = open_valid && (src.bank == open_bank) && (row_word.row == open_row);
    assign go_rw  = (accept && hit) || (st == st_activate);

    always_comb begin
        mode_word = '0;
        mode_word.mode.cas_lat    = 3'(cas_lat);
        mode_word.mode.burst_code = 3'(burst_code);

        row_word = '0;
        row_word.row[row_width-1:0] = src.row[row_width-1:0];

        col_full = '0;
        col_full[col_width-1:0] = src.col[col_width-1:0];
        col_word = '0;
        col_word.col.col_hi = col_full[10];
        col_word.col.col_lo = col_full[9:0];
    end

    assign dq = wr_take ? wr_data : 16'bz;

    always_ff @(posedge clk or negedge cke) begin
        if (!cke) begin
            st         <= st_mode_set;
            busy       <= 1'b1;
            wr_take    <= 1'b0;
            rsp_valid  <= 1'b0;
            cmd        <= cmd_nop;
            a          <= '0;
            ba         <= '0;
            dqm        <= '0;
            open_valid <= 1'b0;
            open_bank  <= '0;
            open_row   <= '0;
            wait_cnt   <= '0;
            beats_left <= '0;
        end else begin
            cmd       <= cmd_nop;
            rsp_valid <= 1'b0;
            case (st)
                st_mode_set: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == 3'd0) begin
                        cmd <= cmd_load_mode;
                        a   <= mode_word;
                    end else if (wait_cnt == 3'd2) begin
                        busy <= 1'b0;
                        st   <= st_idle;
                    end
                end
                st_idle: begin
                    if (accept) begin
                        busy <= 1'b1;
                        if (!hit) begin
                            cmd        <= cmd_activate;
                            a          <= row_word;
                            ba         <= src.bank;
                            open_valid <= 1'b1;
                            open_bank  <= src.bank;
                            open_row   <= row_word.row;
                            st         <= st_activate;
                        end
                    end
                end
                st_write: begin
                    beats_left <= beats_left - 1'b1;
                    if (beats_left == 4'd1) begin
                        wr_take <= 1'b0;
                        busy    <= 1'b0;
                        st      <= st_idle;
                    end
                end
                st_read_wait: begin
                    wait_cnt <= wait_cnt + 1'b1;
                    if (wait_cnt == 3'(cas_lat - 1)) begin
                        st <= st_read_cap;
                    end
                end
                st_read_cap: begin
                    rsp_valid  <= 1'b1;
                    beats_left <= beats_left - 1'b1;
                    if (beats_left == 4'd1) begin
                        busy <= 1'b0;
                        st   <= st_idle;
                    end
                end
                default: st <= st_idle;
            endcase

            // read or write goes out straight on a row hit, else after activate
            if (go_rw) begin
                cmd        <= src.op ? cmd_write : cmd_read;
                a          <= col_word;
                ba         <= src.bank;
                dqm        <= src.mask;
                beats_left <= beat_total;
                wait_cnt   <= '0;
                wr_take    <= src.op;                   // beat 0 rides with the command
                st         <= src.op ? st_write : st_read_wait;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= req;
        end
        if (st == st_read_cap) begin
            rsp.data <= dq;
            rsp.last <= (beats_left == 4'd1);
        end
    end

    a_busy_fall: assert property (@(posedge clk) disable iff (!cke)
        $fell(busy) |-> (beats_left == 4'd0))
        else $error("busy dropped with beats outstanding");

    a_one_dir: assert property (@(posedge clk) disable iff (!cke)
        !(wr_take && rsp_valid))
        else $error("write and read data active together");

endmodule

/* rtl/sdram_subsys_top.sv */
// SDRAM subsystem: controller and behavioral SDRAM joined on the pin nets
`timescale 1ns/1ns

module sdram_subsys_top #(
    parameter int row_width  = 6,
    parameter int col_width  = 5,
    parameter int cas_lat    = 2,
    parameter int burst_code = 2
) (
    input  logic                      clk,
    input  logic                      cke,
    input  logic                      req_valid,
    input  sdram_user_pkg::user_req_t req,
    input  sdram_cmd_pkg::data_t      wr_data,
    output logic                      busy,
    output logic                      wr_take,
    output logic                      rsp_valid,
    output sdram_user_pkg::user_rsp_t rsp
);
    import sdram_cmd_pkg::*;

    sdram_cmd_t  cmd;
    logic [12:0] a;
    bank_t       ba;
    mask_t       dqm;
    wire data_t  dq;                                // shared, tristate on both sides

    sdram_ctrl #(
        .row_width  (row_width),
        .col_width  (col_width),
        .cas_lat    (cas_lat),
        .burst_code (burst_code)
    ) u_ctrl (
        .clk       (clk),
        .cke       (cke),
        .req_valid (req_valid),
        .req       (req),
        .wr_data   (wr_data),
        .busy      (busy),
        .wr_take   (wr_take),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .cmd       (cmd),
        .a         (a),
        .ba        (ba),
        .dqm       (dqm),
        .dq        (dq)
    );

    sdram_model #(
        .row_width (row_width),
        .col_width (col_width)
    ) u_mem (
        .clk (clk),
        .cke (cke),
        .cmd (cmd),
        .a   (a),
        .ba  (ba),
        .dqm (dqm),
        .dq  (dq)
    );

endmodule

/* bench/sdram_ref_model.svh */
// reference memory for the testbench: sparse word store with known-lane flags,
// byte-mask merge and burst column generation
`ifndef SDRAM_REF_MODEL_SVH
`define SDRAM_REF_MODEL_SVH

logic [15:0] ref_mem [int];
logic [1:0]  ref_known [int];                   // lanes written at least once

// only the low row and column bits select a word in the scaled part
function automatic int ref_key(input logic [1:0] bank, input logic [12:0] row,
                               input logic [10:0] col);
    int key;
    key = int'(bank);
    key = (key << row_width) | (int'(row) % (1 << row_width));
    key = (key << col_width) | (int'(col) % (1 << col_width));
    return key;
endfunction

function automatic logic [10:0] burst_col(input logic [10:0] start, input int beat);
    return 11'((int'(start) + beat) % (1 << col_width));    // wraps in the page
endfunction

function automatic void ref_write(input int key, input logic [1:0] mask,
                                  input logic [15:0] data);
    logic [15:0] word;
    logic [1:0]  kn;
    word = ref_mem.exists(key) ? ref_mem[key] : 16'h0;
    kn   = ref_known.exists(key) ? ref_known[key] : 2'b00;
    if (mask[0]) begin
        word[7:0] = data[7:0];
        kn[0]     = 1'b1;
    end
    if (mask[1]) begin
        word[15:8] = data[15:8];
        kn[1]      = 1'b1;
    end
    ref_mem[key]   = word;
    ref_known[key] = kn;
endfunction

function automatic void ref_read(input int key, output logic [15:0] data,
                                 output logic [1:0] kn);
    data = ref_mem.exists(key) ? ref_mem[key] : 16'h0;
    kn   = ref_known.exists(key) ? ref_known[key] : 2'b00;
endfunction

`endif

/* bench/tb_sdram_subsys.sv */
// SDRAM subsystem testbench
// clock, reset and mode setup check, directed and seeded random bursts
// checked against a reference memory, watchdog and result report
`timescale 1ns/1ns

module tb_sdram_subsys;
    import sdram_cmd_pkg::*;
    import sdram_user_pkg::*;

    localparam int row_width    = 6;
    localparam int col_width    = 5;
    localparam int cas_lat      = 2;
    localparam int burst_code   = 2;
    localparam int burst_beats  = 1 << burst_code;     // code 2 gives 4 beats
    localparam int clk_period   = 10;
    localparam int reset_cycles = 8;
    localparam int random_reqs  = 200;
    localparam int total_reqs   = 16 + random_reqs;
    localparam int watchdog_ns  = (total_reqs * 400 + reset_cycles + 16) * clk_period;

    logic      clk;
    logic      cke;
    logic      req_valid;
    user_req_t req;
    data_t     wr_data;
    logic      busy;
    logic      wr_take;
    logic      rsp_valid;
    user_rsp_t rsp;

    integer      seed;
    int          error_count;
    int          check_count;
    int          tests_run;
    int          tests_failed;
    int          test_errs;
    logic [15:0] wr_beats [burst_beats];
    logic        open_valid;                       // row the controller should hold open
    logic [1:0]  open_bank;
    logic [12:0] open_row;

    `include "sdram_ref_model.svh"

    sdram_subsys_top #(
        .row_width  (row_width),
        .col_width  (col_width),
        .cas_lat    (cas_lat),
        .burst_code (burst_code)
    ) u_sdram_subsys_top (
        .clk       (clk),
        .cke       (cke),
        .req_valid (req_valid),
        .req       (req),
        .wr_data   (wr_data),
        .busy      (busy),
        .wr_take   (wr_take),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("run timed out after %0d ns, a request never finished", watchdog_ns);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    task automatic report_fail(input string msg);
        error_count++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_errs) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name,
                     error_count - test_errs);
        end
        test_errs = error_count;
    endtask

    task automatic fill_beats();
        logic [31:0] r;
        for (int b = 0; b < burst_beats; b++) begin
            r           = next_rand();
            wr_beats[b] = r[15:0];
        end
    endtask

    task automatic check_setup();
        int cycles;
        repeat (reset_cycles) begin
            @(negedge clk);
            check_count++;
            if (busy !== 1'b1 || rsp_valid !== 1'b0 || wr_take !== 1'b0) begin
                report_fail($sformatf("in reset busy=%b rsp_valid=%b wr_take=%b",
                                      busy, rsp_valid, wr_take));
            end
        end
        cke    = 1'b1;
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            check_count++;
            if (rsp_valid !== 1'b0 || wr_take !== 1'b0) begin
                report_fail("rsp_valid or wr_take high during mode setup");
            end
        end
        // load mode on edge 1 and busy low from edge 3
        check_count++;
        if (cycles != 3) begin
            report_fail($sformatf("busy fell %0d cycles after reset, expected 3", cycles));
        end
    endtask

    task automatic run_request(input logic op, input logic [1:0] bank,
                               input logic [12:0] row, input logic [10:0] col,
                               input logic [1:0] mask, input bit inject);
        logic [15:0] exp_data [burst_beats];
        logic [1:0]  exp_known [burst_beats];
        logic [15:0] lanes;
        logic [31:0] junk;
        bit          miss;
        bit          done;
        int          cycles;
        int          wr_count;
        int          rd_count;
        int          exp_cycles;
        string       kind;

        for (int b = 0; b < burst_beats; b++) begin
            ref_read(ref_key(bank, row, burst_col(col, b)), exp_data[b], exp_known[b]);
            exp_known[b] = exp_known[b] & mask;        // unmasked lanes float
        end
        miss = !open_valid || bank != open_bank ||
               row[row_width-1:0] != open_row[row_width-1:0];
        exp_cycles = (miss ? 1 : 0) + (op ? burst_beats : cas_lat + burst_beats);

        while (busy) @(negedge clk);
        req.op    = op;
        req.bank  = bank;
        req.row   = row;
        req.col   = col;
        req.mask  = mask;
        req_valid = 1'b1;
        cycles    = 0;
        wr_count  = 0;
        rd_count  = 0;
        done      = 1'b0;
        while (!done) begin
            @(negedge clk);
            req_valid = 1'b0;
            if (rsp_valid) begin
                check_count++;
                if (op || rd_count >= burst_beats) begin
                    report_fail("rsp_valid pulse outside a read burst");
                end else begin
                    lanes = {{8{exp_known[rd_count][1]}}, {8{exp_known[rd_count][0]}}};
                    check_count++;
                    if (((rsp.data ^ exp_data[rd_count]) & lanes) !== 16'h0) begin
                        report_fail($sformatf("read b%0d r%0d c%0d beat %0d got %h exp %h lanes %b",
                                              bank, row, col, rd_count, rsp.data,
                                              exp_data[rd_count], exp_known[rd_count]));
                    end
                    check_count++;
                    if (rsp.last !== (rd_count == burst_beats - 1)) begin
                        report_fail($sformatf("last=%b on beat %0d", rsp.last, rd_count));
                    end
                end
                rd_count++;
            end
            if (wr_take) begin
                check_count++;
                if (!op || wr_count >= burst_beats) begin
                    report_fail("wr_take high outside a write burst");
                end else begin
                    wr_data = wr_beats[wr_count];
                end
                wr_count++;
            end
            if (!busy) begin
                done = 1'b1;
            end else begin
                cycles++;
                if (inject && cycles == 2) begin
                    junk      = next_rand();
                    req       = junk[28:0];
                    req_valid = 1'b1;                  // dropped since busy is high
                end
            end
        end

        if (op) begin
            kind = "write";
        end else begin
            kind = "read";
        end
        check_count++;
        if (cycles != exp_cycles) begin
            report_fail($sformatf("%s busy for %0d cycles, expected %0d",
                                  kind, cycles, exp_cycles));
        end
        check_count++;
        if ((op ? wr_count : rd_count) != burst_beats) begin
            report_fail($sformatf("%0d beats transferred, expected %0d",
                                  op ? wr_count : rd_count, burst_beats));
        end
        if (op) begin
            for (int b = 0; b < burst_beats; b++) begin
                ref_write(ref_key(bank, row, burst_col(col, b)), mask, wr_beats[b]);
            end
        end
        open_valid = 1'b1;
        open_bank  = bank;
        open_row   = row;
    endtask

    task automatic write_burst(input logic [1:0] bank, input logic [12:0] row,
                               input logic [10:0] col, input logic [1:0] mask);
        fill_beats();
        run_request(1'b1, bank, row, col, mask, 1'b0);
    endtask

    task automatic read_burst(input logic [1:0] bank, input logic [12:0] row,
                              input logic [10:0] col, input logic [1:0] mask);
        run_request(1'b0, bank, row, col, mask, 1'b0);
    endtask

    initial begin : main_seq
        logic [31:0] r;
        seed         = 32'h5efa;
        cke          = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        wr_data      = '0;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_errs    = 0;
        open_valid   = 1'b0;
        open_bank    = '0;
        open_row     = '0;

        check_setup();
        finish_test("reset and mode setup");

        write_burst(2'd0, 13'd3, 11'd4, 2'b11);
        read_burst(2'd0, 13'd3, 11'd4, 2'b11);
        finish_test("full burst write and read");

        write_burst(2'd1, 13'd5, 11'd8, 2'b11);
        write_burst(2'd1, 13'd5, 11'd8, 2'b01);        // low lane only
        read_burst(2'd1, 13'd5, 11'd8, 2'b11);
        finish_test("byte mask merge");

        write_burst(2'd0, 13'd1, 11'd7, 2'b11);
        write_burst(2'd1, 13'd1, 11'd7, 2'b11);
        write_burst(2'd2, 13'd9, 11'd7, 2'b11);
        write_burst(2'd0, 13'd9, 11'd7, 2'b11);
        read_burst(2'd0, 13'd1, 11'd7, 2'b11);
        read_burst(2'd1, 13'd1, 11'd7, 2'b11);
        read_burst(2'd2, 13'd9, 11'd7, 2'b11);
        read_burst(2'd0, 13'd9, 11'd7, 2'b11);
        finish_test("bank and row switching");

        write_burst(2'd3, 13'd2, 11'd30, 2'b11);
        read_burst(2'd3, 13'd2, 11'd30, 2'b11);
        read_burst(2'd3, 13'd2, 11'd0, 2'b11);         // beats 2 and 3 landed here
        finish_test("column wrap");

        for (int i = 0; i < random_reqs; i++) begin
            r = next_rand();
            if (r[0]) begin
                fill_beats();
            end
            run_request(r[0], r[2:1], {11'd0, r[4:3]}, {6'd0, r[9:5]}, r[11:10],
                        r[13] & r[12]);
        end
        finish_test("random mix");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+bench
rtl/sdram_cmd_pkg.sv
rtl/sdram_user_pkg.sv
rtl/sdram_model.sv
rtl/sdram_ctrl.sv
rtl/sdram_subsys_top.sv
bench/tb_sdram_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the SDRAM subsystem testbench
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_sdram_subsys \
    -Mdir obj_dir -o tb_sdram_subsys
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sdram_subsys > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$log"; then
    exit 1
fi
exit 0
